// ==== logic/rowbuf_pkg.sv ====
package rowbuf_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int PIXEL_WIDTH = 18;
    localparam int COL_WIDTH   = 9;
    localparam int NUM_BANKS   = 4;

    typedef logic [PIXEL_WIDTH-1:0]           pixel_t;
    typedef logic [COL_WIDTH-1:0]             col_t;
    // Half bit on top, column below
    typedef logic [COL_WIDTH:0]               bank_addr_t;
    // Bit 0 even-bank half, bit 1 odd-bank half
    typedef logic [1:0]                       gray_t;
    // Bank 3 in the top pixel, bank 0 in the bottom one
    typedef logic [NUM_BANKS*PIXEL_WIDTH-1:0] quad_pixel_t;

    // Driven by the outer controller
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_PRIM_LOAD,
        PH_ACTIVE,
        PH_FIN
    } phase_t;

    typedef struct packed {
        logic                 row_sel;
        logic [COL_WIDTH-2:0] col_hi;
        logic                 parity;
    } seq_word_t;

    //////////////////////////////////////////////////////////////////////
    // Bank port commands
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic       en;
        bank_addr_t addr;
        pixel_t     data;
    } bank_wr_t;

    typedef struct packed {
        logic       en;
        bank_addr_t addr;
    } bank_rd_t;

endpackage

// ==== logic/row_bank_ram.sv ====
`timescale 1ns/1ns

module row_bank_ram import rowbuf_pkg::*; #(
    parameter int ROW_COLS = 320
) (
    input  logic     clk_500MHz,
    input  bank_wr_t wr,
    input  bank_rd_t rd,
    output pixel_t   rdata
);

    localparam int DEPTH = 2 * ROW_COLS;
    localparam int IDX_W = $clog2(DEPTH);

    pixel_t           mem [DEPTH];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Half 1 starts right after the last column of half 0
    assign wr_idx = IDX_W'(wr.addr[COL_WIDTH] ? ROW_COLS + int'(wr.addr[COL_WIDTH-1:0])
                                              : int'(wr.addr[COL_WIDTH-1:0]));
    assign rd_idx = IDX_W'(rd.addr[COL_WIDTH] ? ROW_COLS + int'(rd.addr[COL_WIDTH-1:0])
                                              : int'(rd.addr[COL_WIDTH-1:0]));

    always_ff @(posedge clk_500MHz) begin
        if (wr.en) begin
            mem[wr_idx] <= wr.data;
        end
        if (rd.en) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

// ==== logic/prim_buffer_loader.sv ====
`timescale 1ns/1ns

module prim_buffer_loader import rowbuf_pkg::*; #(
    parameter int ROW_COLS = 320
) (
    input  logic     clk_500MHz,
    input  logic     rst,
    input  phase_t   phase,
    input  pixel_t   pix_in,
    input  logic     pix_in_valid,
    input  logic [1:0] load_row,
    input  col_t     load_col,
    output bank_wr_t load_wr [NUM_BANKS]
);

    logic                 take;
    logic [NUM_BANKS-1:0] bank_hit;
    logic                 half;

    assign take = (phase == PH_PRIM_LOAD) && pix_in_valid && (int'(load_col) < ROW_COLS);

    // Row 0 fills half 0 everywhere, rows 1 and 2 fill half 1 of odd or even banks
    always_comb begin
        case (load_row)
            2'd0:    begin bank_hit = 4'b1111; half = 1'b0; end
            2'd1:    begin bank_hit = 4'b1010; half = 1'b1; end
            2'd2:    begin bank_hit = 4'b0101; half = 1'b1; end
            default: begin bank_hit = 4'b0000; half = 1'b0; end
        endcase
    end

    always_ff @(posedge clk_500MHz) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            load_wr[b].addr <= {half, load_col};
            load_wr[b].data <= pix_in;
            if (rst) begin
                load_wr[b].en <= 1'b0;
            end else begin
                load_wr[b].en <= take && bank_hit[b];
            end
        end
    end

endmodule

// ==== logic/window_read_sequencer.sv ====
`timescale 1ns/1ns

module window_read_sequencer import rowbuf_pkg::*; (
    input  logic        clk_500MHz,
    input  logic        rst,
    input  phase_t      phase,
    input  gray_t       gray_code,
    input  seq_word_t   seq_word,
    input  logic        seq_valid,
    input  pixel_t      bank_rdata [NUM_BANKS],
    output bank_rd_t    seq_rd_even,
    output bank_rd_t    seq_rd_odd,
    output quad_pixel_t pix_out,
    output logic        pix_out_valid
);

    logic       req;
    bank_addr_t even_addr;
    bank_addr_t odd_addr;
    // Tracks the read through the arbiter and the RAM
    logic [1:0] vld_pipe;

    assign req = (phase == PH_ACTIVE) && seq_valid;

    //////////////////////////////////////////////////////////////////////
    // Address forming
    //////////////////////////////////////////////////////////////////////
    // Even banks always hold the even column of the pair
    assign even_addr = {gray_code[0] ^ seq_word.row_sel, seq_word.col_hi, 1'b0};
    assign odd_addr  = {gray_code[1] ^ seq_word.row_sel, seq_word.col_hi, seq_word.parity};

    always_ff @(posedge clk_500MHz) begin
        seq_rd_even.addr <= even_addr;
        seq_rd_odd.addr  <= odd_addr;
        if (rst) begin
            seq_rd_even.en <= 1'b0;
            seq_rd_odd.en  <= 1'b0;
            vld_pipe       <= '0;
            pix_out_valid  <= 1'b0;
        end else begin
            seq_rd_even.en <= req;
            seq_rd_odd.en  <= req;
            vld_pipe       <= {vld_pipe[0], seq_rd_even.en};
            pix_out_valid  <= vld_pipe[1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output capture
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (vld_pipe[1]) begin
            pix_out <= {bank_rdata[3], bank_rdata[2], bank_rdata[1], bank_rdata[0]};
        end
    end

endmodule

// ==== logic/row_renamer.sv ====
`timescale 1ns/1ns

module row_renamer import rowbuf_pkg::*; #(
    parameter int ROW_COLS = 320
) (
    input  logic     clk_500MHz,
    input  logic     rst,
    input  phase_t   phase,
    input  gray_t    gray_code,
    input  logic     rename_valid,
    input  col_t     rename_col,
    input  pixel_t   pix_in,
    input  pixel_t   bank_rdata [NUM_BANKS],
    output bank_rd_t ren_rd_odd,
    output bank_wr_t ren_wr_even [NUM_BANKS/2],
    output bank_wr_t ren_wr_odd
);

    typedef struct packed {
        logic   vld;
        col_t   col;
        logic   half_even;
        logic   half_odd;
        pixel_t pix;
    } ren_stage_t;

    logic       take;
    // Request stage drives the odd-bank read
    ren_stage_t req;
    // Two stages cover the arbiter and RAM read latency
    ren_stage_t pipe [2];

    assign take = (phase == PH_FIN) && rename_valid && (int'(rename_col) < ROW_COLS);

    always_ff @(posedge clk_500MHz) begin
        req.col       <= rename_col;
        req.half_even <= gray_code[0];
        req.half_odd  <= gray_code[1];
        req.pix       <= pix_in;
        pipe[0]       <= req;
        pipe[1]       <= pipe[0];
        if (rst) begin
            req.vld     <= 1'b0;
            pipe[0].vld <= 1'b0;
            pipe[1].vld <= 1'b0;
        end else begin
            req.vld <= take;
        end
    end

    assign ren_rd_odd.en   = req.vld;
    assign ren_rd_odd.addr = {req.half_odd, req.col};

    //////////////////////////////////////////////////////////////////////
    // Write back
    //////////////////////////////////////////////////////////////////////
    // Odd row data lands in the even banks, bank 1 into 0 and bank 3 into 2
    assign ren_wr_even[0].en   = pipe[1].vld;
    assign ren_wr_even[0].addr = {pipe[1].half_even, pipe[1].col};
    assign ren_wr_even[0].data = bank_rdata[1];
    assign ren_wr_even[1].en   = pipe[1].vld;
    assign ren_wr_even[1].addr = {pipe[1].half_even, pipe[1].col};
    assign ren_wr_even[1].data = bank_rdata[3];

    // Incoming pixel replaces what was read
    assign ren_wr_odd.en   = pipe[1].vld;
    assign ren_wr_odd.addr = {pipe[1].half_odd, pipe[1].col};
    assign ren_wr_odd.data = pipe[1].pix;

endmodule

// ==== logic/bank_port_arbiter.sv ====
`timescale 1ns/1ns

module bank_port_arbiter import rowbuf_pkg::*; (
    input  logic     clk_500MHz,
    input  logic     rst,
    input  bank_wr_t load_wr [NUM_BANKS],
    input  bank_rd_t seq_rd_even,
    input  bank_rd_t seq_rd_odd,
    input  bank_rd_t ren_rd_odd,
    input  bank_wr_t ren_wr_even [NUM_BANKS/2],
    input  bank_wr_t ren_wr_odd,
    output bank_wr_t bank_wr [NUM_BANKS],
    output bank_rd_t bank_rd [NUM_BANKS]
);

    bank_wr_t wr_sel [NUM_BANKS];
    bank_rd_t rd_sel [NUM_BANKS];

    //////////////////////////////////////////////////////////////////////
    // Fixed priority, renamer first
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (b % 2 == 1) begin
                wr_sel[b] = ren_wr_odd.en ? ren_wr_odd : load_wr[b];
                rd_sel[b] = ren_rd_odd.en ? ren_rd_odd : seq_rd_odd;
            end else begin
                wr_sel[b] = ren_wr_even[b/2].en ? ren_wr_even[b/2] : load_wr[b];
                // Nothing else reads the even banks
                rd_sel[b] = seq_rd_even;
            end
        end
    end

    always_ff @(posedge clk_500MHz) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_wr[b].addr <= wr_sel[b].addr;
            bank_wr[b].data <= wr_sel[b].data;
            bank_rd[b].addr <= rd_sel[b].addr;
            if (rst) begin
                bank_wr[b].en <= 1'b0;
                bank_rd[b].en <= 1'b0;
            end else begin
                bank_wr[b].en <= wr_sel[b].en;
                bank_rd[b].en <= rd_sel[b].en;
            end
        end
    end

endmodule

// ==== logic/awe_rowbuffers.sv ====
`timescale 1ns/1ns

module awe_rowbuffers import rowbuf_pkg::*; #(
    parameter int ROW_COLS = 320
) (
    input  logic        clk_500MHz,
    input  logic        rst,
    input  phase_t      phase,
    input  gray_t       gray_code,
    input  pixel_t      pix_in,
    input  logic        pix_in_valid,
    input  logic [1:0]  load_row,
    input  col_t        load_col,
    input  seq_word_t   seq_word,
    input  logic        seq_valid,
    input  logic        rename_valid,
    input  col_t        rename_col,
    output quad_pixel_t pix_out,
    output logic        pix_out_valid
);

    //////////////////////////////////////////////////////////////////////
    // Engine to arbiter commands
    //////////////////////////////////////////////////////////////////////
    bank_wr_t load_wr     [NUM_BANKS];
    bank_rd_t seq_rd_even;
    bank_rd_t seq_rd_odd;
    bank_rd_t ren_rd_odd;
    bank_wr_t ren_wr_even [NUM_BANKS/2];
    bank_wr_t ren_wr_odd;

    // Registered bank ports and RAM data
    bank_wr_t bank_wr    [NUM_BANKS];
    bank_rd_t bank_rd    [NUM_BANKS];
    pixel_t   bank_rdata [NUM_BANKS];

    prim_buffer_loader #(.ROW_COLS(ROW_COLS)) u_loader (
        .clk_500MHz   (clk_500MHz),
        .rst          (rst),
        .phase        (phase),
        .pix_in       (pix_in),
        .pix_in_valid (pix_in_valid),
        .load_row     (load_row),
        .load_col     (load_col),
        .load_wr      (load_wr)
    );

    window_read_sequencer u_sequencer (
        .clk_500MHz    (clk_500MHz),
        .rst           (rst),
        .phase         (phase),
        .gray_code     (gray_code),
        .seq_word      (seq_word),
        .seq_valid     (seq_valid),
        .bank_rdata    (bank_rdata),
        .seq_rd_even   (seq_rd_even),
        .seq_rd_odd    (seq_rd_odd),
        .pix_out       (pix_out),
        .pix_out_valid (pix_out_valid)
    );

    row_renamer #(.ROW_COLS(ROW_COLS)) u_renamer (
        .clk_500MHz   (clk_500MHz),
        .rst          (rst),
        .phase        (phase),
        .gray_code    (gray_code),
        .rename_valid (rename_valid),
        .rename_col   (rename_col),
        .pix_in       (pix_in),
        .bank_rdata   (bank_rdata),
        .ren_rd_odd   (ren_rd_odd),
        .ren_wr_even  (ren_wr_even),
        .ren_wr_odd   (ren_wr_odd)
    );

    bank_port_arbiter u_arbiter (
        .clk_500MHz  (clk_500MHz),
        .rst         (rst),
        .load_wr     (load_wr),
        .seq_rd_even (seq_rd_even),
        .seq_rd_odd  (seq_rd_odd),
        .ren_rd_odd  (ren_rd_odd),
        .ren_wr_even (ren_wr_even),
        .ren_wr_odd  (ren_wr_odd),
        .bank_wr     (bank_wr),
        .bank_rd     (bank_rd)
    );

    //////////////////////////////////////////////////////////////////////
    // Banks 0 and 2 even, 1 and 3 odd
    //////////////////////////////////////////////////////////////////////
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        row_bank_ram #(.ROW_COLS(ROW_COLS)) u_ram (
            .clk_500MHz (clk_500MHz),
            .wr         (bank_wr[b]),
            .rd         (bank_rd[b]),
            .rdata      (bank_rdata[b])
        );
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_500MHz,
    output logic rst
);

    initial begin
        clk_500MHz = 1'b0;
        forever #(HALF_PERIOD) clk_500MHz = ~clk_500MHz;
    end

    // Released on a falling edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_500MHz);
        @(negedge clk_500MHz);
        rst = 1'b0;
    end

endmodule

// ==== verif/awe_rowbuffers_properties.sv ====
`timescale 1ns/1ns

module awe_rowbuffers_properties import rowbuf_pkg::*; (
    input logic     clk_500MHz,
    input logic     rst,
    input phase_t   phase,
    input logic     seq_valid,
    input logic     pix_out_valid,
    input bank_wr_t bank_wr [NUM_BANKS]
);

    int unsigned assert_fails = 0;
    logic        any_wr_en;

    assign any_wr_en = bank_wr[0].en | bank_wr[1].en | bank_wr[2].en | bank_wr[3].en;

    // Valid cleared by every reset edge
    a_valid_low_in_reset: assert property (@(posedge clk_500MHz) rst |=> !pix_out_valid)
        else begin
            $error("pix_out_valid high after a reset cycle");
            assert_fails++;
        end

    // Output registered on the third edge after the request, seen at the fourth
    a_read_latency: assert property (@(posedge clk_500MHz) disable iff (rst)
        (phase == PH_ACTIVE && seq_valid) |-> ##4 pix_out_valid)
        else begin
            $error("pix_out_valid missing after a window read request");
            assert_fails++;
        end

    // Banks are read only while the window is active
    a_no_write_when_active: assert property (@(posedge clk_500MHz) disable iff (rst)
        (phase == PH_ACTIVE) |-> !any_wr_en)
        else begin
            $error("bank write enable high in PH_ACTIVE");
            assert_fails++;
        end

endmodule

bind awe_rowbuffers awe_rowbuffers_properties u_props (
    .clk_500MHz    (clk_500MHz),
    .rst           (rst),
    .phase         (phase),
    .seq_valid     (seq_valid),
    .pix_out_valid (pix_out_valid),
    .bank_wr       (bank_wr)
);

// ==== verif/awe_rowbuffers_tb.sv ====
`timescale 1ns/1ns

module awe_rowbuffers_tb import rowbuf_pkg::*; ();

    localparam int          ROW_COLS   = 320;
    localparam int          RAM_DEPTH  = 2 * ROW_COLS;
    localparam int          WAIT_LIMIT = 50;
    localparam logic [31:0] LFSR_SEED  = 32'ha5299b64;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    logic        clk_500MHz;
    logic        rst;
    phase_t      phase;
    gray_t       gray_code;
    pixel_t      pix_in;
    logic        pix_in_valid;
    logic [1:0]  load_row;
    col_t        load_col;
    seq_word_t   seq_word;
    logic        seq_valid;
    logic        rename_valid;
    col_t        rename_col;
    quad_pixel_t pix_out;
    logic        pix_out_valid;

    logic [31:0] lfsr_state = LFSR_SEED;
    int          edge_cnt   = 0;
    int          reads_seen = 0;
    // Same half and column layout as the bank RAMs
    pixel_t      model_mem [NUM_BANKS][RAM_DEPTH];
    int          exp_due [$];
    quad_pixel_t exp_quad [$];
    col_t        probe_cols [$];
    bit          renamed [ROW_COLS];

    tb_clock_gen #(.HALF_PERIOD(20), .RESET_CYCLES(3)) u_clock_gen (
        .clk_500MHz (clk_500MHz),
        .rst        (rst)
    );

    awe_rowbuffers #(.ROW_COLS(ROW_COLS)) DUT (
        .clk_500MHz    (clk_500MHz),
        .rst           (rst),
        .phase         (phase),
        .gray_code     (gray_code),
        .pix_in        (pix_in),
        .pix_in_valid  (pix_in_valid),
        .load_row      (load_row),
        .load_col      (load_col),
        .seq_word      (seq_word),
        .seq_valid     (seq_valid),
        .rename_valid  (rename_valid),
        .rename_col    (rename_col),
        .pix_out       (pix_out),
        .pix_out_valid (pix_out_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Random numbers and model
    //////////////////////////////////////////////////////////////////////
    // Galois LFSR, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic int ram_index(input logic half, input int col);
        return half ? ROW_COLS + col : col;
    endfunction

    // Even banks see column 2*col_hi, odd banks 2*col_hi + parity
    function automatic quad_pixel_t model_quad(input seq_word_t w, input gray_t g);
        int even_idx;
        int odd_idx;
        even_idx = ram_index(g[0] ^ w.row_sel, 2 * int'(w.col_hi));
        odd_idx  = ram_index(g[1] ^ w.row_sel, 2 * int'(w.col_hi) + int'(w.parity));
        return {model_mem[3][odd_idx], model_mem[2][even_idx],
                model_mem[1][odd_idx], model_mem[0][even_idx]};
    endfunction

    function automatic seq_word_t random_word();
        seq_word_t w;
        w.row_sel = 1'(next_bits(1));
        w.col_hi  = 8'(next_bits(8) % (ROW_COLS / 2));
        w.parity  = 1'(next_bits(1));
        return w;
    endfunction

    function automatic seq_word_t word_for_col(input col_t col, input logic row_sel);
        seq_word_t w;
        w.row_sel = row_sel;
        w.col_hi  = col[COL_WIDTH-1:1];
        w.parity  = col[0];
        return w;
    endfunction

    // Steps forward past columns already renamed
    function automatic col_t pick_fresh_col();
        int col;
        col = int'(next_bits(COL_WIDTH) % ROW_COLS);
        for (int i = 0; i < ROW_COLS && renamed[col]; i++) begin
            col = (col + 1) % ROW_COLS;
        end
        renamed[col] = 1'b1;
        return col_t'(col);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_quad(input quad_pixel_t got, input quad_pixel_t exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, expected %h, got %h",
                     $time, what, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_valid(input logic got, input bit exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, expected %b, got %b",
                     $time, what, exp, got);
            stop_on_failure();
        end
    endtask

    always @(posedge clk_500MHz) begin
        edge_cnt <= edge_cnt + 1;
    end

    // Outputs are sampled half a cycle after they change
    always @(negedge clk_500MHz) begin
        if (DUT.u_props.assert_fails != 0) begin
            $display("A bound assertion failed, see the error reported above");
            stop_on_failure();
        end
        if (!rst) begin
            if (exp_due.size() > 0 && exp_due[0] == edge_cnt) begin
                check_valid(pix_out_valid, 1'b1, "pix_out_valid on its due cycle");
                check_quad(pix_out, exp_quad[0], "pix_out for window read");
                void'(exp_due.pop_front());
                void'(exp_quad.pop_front());
                reads_seen++;
            end else begin
                check_valid(pix_out_valid, 1'b0, "pix_out_valid with no read due");
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////////////////////////
    task automatic clear_strobes();
        pix_in_valid = 1'b0;
        seq_valid    = 1'b0;
        rename_valid = 1'b0;
    endtask

    // Idle gap lets pending bank writes land before the new phase
    task automatic set_phase(input phase_t p);
        @(negedge clk_500MHz);
        clear_strobes();
        phase = PH_IDLE;
        repeat (4) @(negedge clk_500MHz);
        phase = p;
    endtask

    task automatic load_pixel(input logic [1:0] row, input col_t col, input pixel_t pix);
        @(negedge clk_500MHz);
        clear_strobes();
        pix_in_valid = 1'b1;
        load_row     = row;
        load_col     = col;
        pix_in       = pix;
        if (int'(col) < ROW_COLS) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (row == 2'd0) begin
                    model_mem[b][ram_index(1'b0, int'(col))] = pix;
                end else if ((row == 2'd1 && b % 2 == 1) || (row == 2'd2 && b % 2 == 0)) begin
                    model_mem[b][ram_index(1'b1, int'(col))] = pix;
                end
            end
        end
    endtask

    task automatic issue_read(input seq_word_t w);
        @(negedge clk_500MHz);
        clear_strobes();
        seq_valid = 1'b1;
        seq_word  = w;
        exp_due.push_back(edge_cnt + 4);
        exp_quad.push_back(model_quad(w, gray_code));
    endtask

    // Odd pixels move to the even banks, incoming pixel takes their place
    task automatic rename_pixel(input col_t col, input pixel_t pix);
        int even_idx;
        int odd_idx;
        @(negedge clk_500MHz);
        clear_strobes();
        rename_valid = 1'b1;
        rename_col   = col;
        pix_in       = pix;
        even_idx = ram_index(gray_code[0], int'(col));
        odd_idx  = ram_index(gray_code[1], int'(col));
        model_mem[0][even_idx] = model_mem[1][odd_idx];
        model_mem[2][even_idx] = model_mem[3][odd_idx];
        model_mem[1][odd_idx]  = pix;
        model_mem[3][odd_idx]  = pix;
    endtask

    task automatic wait_for_reads(input string what);
        int waited;
        waited = 0;
        @(negedge clk_500MHz);
        clear_strobes();
        while (exp_due.size() > 0) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timeout: %0d %s never came back", exp_due.size(), what);
                stop_on_failure();
            end else begin
                @(negedge clk_500MHz);
                waited++;
            end
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst !== 1'b0) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timeout: reset was never released");
                stop_on_failure();
            end else begin
                @(negedge clk_500MHz);
                waited++;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        col_t       col;
        pixel_t     pix;
        logic [1:0] row;
        phase        = PH_IDLE;
        gray_code    = '0;
        pix_in       = '0;
        pix_in_valid = 1'b0;
        load_row     = '0;
        load_col     = '0;
        seq_word     = '0;
        seq_valid    = 1'b0;
        rename_valid = 1'b0;
        rename_col   = '0;
        wait_reset_release();

        // Quiet after reset
        repeat (10) begin
            @(negedge clk_500MHz);
            check_valid(pix_out_valid, 1'b0, "pix_out_valid idle after reset");
        end

        // Full primary load, then random reads, some back to back
        set_phase(PH_PRIM_LOAD);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < ROW_COLS; c++) begin
                pix = pixel_t'(next_bits(PIXEL_WIDTH));
                load_pixel(2'(r), col_t'(c), pix);
            end
        end
        set_phase(PH_ACTIVE);
        gray_code = gray_t'(next_bits(2));
        for (int i = 0; i < 200; i++) begin
            issue_read(random_word());
            if (next_bits(2) == 0) begin
                @(negedge clk_500MHz);
                clear_strobes();
            end
        end
        wait_for_reads("random window reads");

        // Ignored loads: columns past the row, and row 3
        set_phase(PH_PRIM_LOAD);
        for (int i = 0; i < 16; i++) begin
            col = col_t'(ROW_COLS + next_bits(COL_WIDTH) % (2**COL_WIDTH - ROW_COLS));
            row = 2'(next_bits(2) % 3);
            pix = pixel_t'(next_bits(PIXEL_WIDTH));
            load_pixel(row, col, pix);
            probe_cols.push_back(col_t'(int'(col) - ROW_COLS));
            col = col_t'(next_bits(COL_WIDTH) % ROW_COLS);
            pix = pixel_t'(next_bits(PIXEL_WIDTH));
            load_pixel(2'd3, col, pix);
            probe_cols.push_back(col);
        end
        set_phase(PH_ACTIVE);
        foreach (probe_cols[i]) begin
            issue_read(word_for_col(probe_cols[i], 1'b0));
            issue_read(word_for_col(probe_cols[i], 1'b1));
        end
        wait_for_reads("reads after ignored loads");

        // Renames of distinct columns in the finish phase
        probe_cols.delete();
        set_phase(PH_FIN);
        gray_code = gray_t'(next_bits(2));
        for (int i = 0; i < 24; i++) begin
            col = pick_fresh_col();
            pix = pixel_t'(next_bits(PIXEL_WIDTH));
            rename_pixel(col, pix);
            probe_cols.push_back(col);
        end
        set_phase(PH_ACTIVE);
        foreach (probe_cols[i]) begin
            issue_read(word_for_col(probe_cols[i], 1'b0));
            issue_read(word_for_col(probe_cols[i], 1'b1));
        end
        wait_for_reads("reads of renamed columns");

        // Every gray code value, half picked by the XOR rule
        for (int g = 0; g < 4; g++) begin
            @(negedge clk_500MHz);
            clear_strobes();
            gray_code = gray_t'(g);
            for (int i = 0; i < 32; i++) begin
                issue_read(random_word());
            end
        end
        wait_for_reads("reads under every gray code");

        $display("%0d window reads checked", reads_seen);
        if (DUT.u_props.assert_fails == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", DUT.u_props.assert_fails);
            stop_on_failure();
        end
    end

endmodule

// ==== filelist.f ====
logic/rowbuf_pkg.sv
logic/row_bank_ram.sv
logic/prim_buffer_loader.sv
logic/window_read_sequencer.sv
logic/row_renamer.sv
logic/bank_port_arbiter.sv
logic/awe_rowbuffers.sv
verif/tb_clock_gen.sv
verif/awe_rowbuffers_properties.sv
verif/awe_rowbuffers_tb.sv

// ==== Bender.yml ====
package:
  name: awe_rowbuffers

sources:
  # RTL
  - files:
      - logic/rowbuf_pkg.sv
      - logic/row_bank_ram.sv
      - logic/prim_buffer_loader.sv
      - logic/window_read_sequencer.sv
      - logic/row_renamer.sv
      - logic/bank_port_arbiter.sv
      - logic/awe_rowbuffers.sv

  # Verification
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/awe_rowbuffers_properties.sv
      - verif/awe_rowbuffers_tb.sv
